//--- verilog/sw_macros.svh
// smith-waterman engine sizing
// array length and the widths of every score and position field

`ifndef SW_MACROS_SVH
`define SW_MACROS_SVH

//////////////////////////////////////////////////
// array size
//////////////////////////////////////////////////
`define SW_NUM_CELLS 8    // one cell per query base, so also the max query length

//////////////////////////////////////////////////
// field widths
//////////////////////////////////////////////////
`define SW_SCORE_W   10   // signed score
`define SW_BASE_W    2    // nucleotide code
`define SW_QPOS_W    3    // query index, covers SW_NUM_CELLS
`define SW_TPOS_W    8    // target position, max target length 256

`endif

//--- verilog/sw_pkg.sv
// smith-waterman shared types
// scores, bases, target beats and the links passed between cells

`include "sw_macros.svh"

package sw_pkg;

    typedef logic signed [`SW_SCORE_W-1:0] score_t;   // two's complement score
    typedef logic [`SW_BASE_W-1:0]         base_t;    // A/C/G/T code
    typedef logic [`SW_QPOS_W-1:0]         qpos_t;    // query index = cell index
    typedef logic [`SW_TPOS_W-1:0]         tpos_t;    // target base position

    typedef struct packed {
        score_t match;      // positive
        score_t mismatch;   // zero or negative
        score_t gap_open;   // zero or negative, linear gap
    } score_cfg_t;

    typedef struct packed {
        base_t base;
        logic  en;          // low means the cell just passes scores through
    } query_slot_t;

    // start beats open an alignment and carry no base
    typedef struct packed {
        logic  valid;
        logic  start;
        logic  last;        // final base beat of the target
        base_t base;
    } target_beat_t;

    typedef struct packed {
        score_t h;          // H[i,j] of the sending cell
        score_t h_max;      // running local max over the cells above
        qpos_t  h_max_i;    // query index where h_max was found
    } cell_link_t;

    typedef struct packed {
        score_t best_score;
        qpos_t  best_query_pos;
        tpos_t  best_target_pos;
    } align_result_t;

endpackage

//--- verilog/query_loader.sv
// query loader
// writes query bases into per-cell slots and flags them enabled

`timescale 1ns/1ps
`include "sw_macros.svh"

module query_loader import sw_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            query_clear,  // empties all slots
    input  logic                            query_load,   // writes the next slot
    input  base_t                           query_base,
    output query_slot_t [`SW_NUM_CELLS-1:0] slots
);

    localparam int PTR_W = $clog2(`SW_NUM_CELLS + 1);   // counts 0..SW_NUM_CELLS

    logic [PTR_W-1:0]         wr_ptr;      // next free slot
    qpos_t                    wr_idx;
    logic                     full;
    logic                     do_write;
    logic [`SW_NUM_CELLS-1:0] ens;         // slot enables
    base_t                    bases [`SW_NUM_CELLS];

    assign full     = (wr_ptr == PTR_W'(`SW_NUM_CELLS));
    assign wr_idx   = wr_ptr[`SW_QPOS_W-1:0];
    assign do_write = query_load && !query_clear && !full;   // clear wins, overflow dropped

    //////////////////////////////////////////////////
    // write pointer and enables
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            ens    <= '0;
        end else if (query_clear) begin
            wr_ptr <= '0;
            ens    <= '0;
        end else if (do_write) begin
            ens[wr_idx] <= 1'b1;
            wr_ptr      <= wr_ptr + 1'b1;
        end
    end

    // base storage
    always_ff @(posedge clk) begin
        if (do_write)
            bases[wr_idx] <= query_base;
    end

    always_comb begin
        for (int k = 0; k < `SW_NUM_CELLS; k++) begin
            slots[k].base = bases[k];
            slots[k].en   = ens[k];
        end
    end

    // the query never outgrows the array
    a_no_load_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        query_load && !query_clear |-> !full);

endmodule

//--- verilog/sw_cell.sv
// smith-waterman scoring cell
// one query base, linear gap, local clipping and running max tracking

`timescale 1ns/1ps

module sw_cell import sw_pkg::*; #(
    parameter int INDEX = 0     // position in the array = query index
) (
    input  logic         clk,
    input  logic         rst_n,
    input  score_cfg_t   cfg,
    input  query_slot_t  slot,       // query base held by the loader
    input  target_beat_t beat_in,
    input  cell_link_t   link_in,    // from the cell above
    output target_beat_t beat_out,
    output cell_link_t   link_out    // to the cell below, link_out.h is also h_left
);

    score_t h_diag;        // H[i-1,j-1], h_in of the previous base beat
    score_t sub;           // substitution score
    score_t diag_score;
    score_t left_raw;
    score_t up_raw;
    score_t gap_left;      // clipped E
    score_t gap_up;        // clipped F
    score_t next_h;
    logic   base_beat;
    logic   start_beat;
    logic   keep_stored;   // stored max wins
    logic   take_above;    // max from the cell above wins

    // signed max
    function automatic score_t smax(score_t a, score_t b);
        return (a < b) ? b : a;
    endfunction

    assign base_beat  = beat_in.valid && !beat_in.start;
    assign start_beat = beat_in.valid && beat_in.start;

    //////////////////////////////////////////////////
    // H recurrence
    //////////////////////////////////////////////////
    always_comb begin
        sub        = (slot.base == beat_in.base) ? cfg.match : cfg.mismatch;
        diag_score = h_diag + sub;
        left_raw   = link_out.h + cfg.gap_open;   // gap along the target
        up_raw     = link_in.h + cfg.gap_open;    // gap along the query
        gap_left   = smax(left_raw, '0);          // local alignment clips at zero
        gap_up     = smax(up_raw, '0);
        if (slot.en)
            next_h = smax(diag_score, smax(gap_left, gap_up));
        else
            next_h = link_in.h;                   // unused cell, pass through
    end

    // max priority is stored, then above, then new
    // ties on the stored value keep the earliest target position
    always_comb begin
        keep_stored = (link_out.h_max >= link_in.h_max) && (link_out.h_max >= next_h);
        take_above  = !keep_stored && (link_in.h_max >= next_h);
    end

    //////////////////////////////////////////////////
    // cell registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_out <= '0;
            link_out <= '0;
            h_diag   <= '0;
        end else begin
            beat_out <= beat_in;                      // one cycle per cell
            if (start_beat) begin
                link_out <= '0;                       // H[i,-1] = 0, max restarts
                h_diag   <= '0;
            end else if (base_beat) begin
                link_out.h <= next_h;
                h_diag     <= link_in.h;
                if (take_above) begin
                    link_out.h_max   <= link_in.h_max;
                    link_out.h_max_i <= link_in.h_max_i;
                end else if (!keep_stored) begin
                    link_out.h_max   <= next_h;
                    link_out.h_max_i <= qpos_t'(INDEX);
                end
            end
            // valid low gaps hold everything
        end
    end

    // holds only if every cell above also clips its gaps
    a_h_not_negative: assert property (@(posedge clk) disable iff (!rst_n)
        link_out.h >= 0);

endmodule

//--- verilog/sw_array.sv
// smith-waterman systolic array
// chain of scoring cells, target beats and score links move one cell per cycle

`timescale 1ns/1ps
`include "sw_macros.svh"

module sw_array import sw_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  score_cfg_t                      cfg,
    input  query_slot_t [`SW_NUM_CELLS-1:0] slots,
    input  target_beat_t                    beat_in,
    output target_beat_t                    tail_beat,   // from the last cell
    output cell_link_t                      tail_link
);

    // stage k feeds cell k, stage SW_NUM_CELLS is the tail
    target_beat_t beat_chain [`SW_NUM_CELLS+1];
    cell_link_t   link_chain [`SW_NUM_CELLS+1];

    assign beat_chain[0] = beat_in;
    assign link_chain[0] = '0;      // row above the query is all zero

    //////////////////////////////////////////////////
    // cells
    //////////////////////////////////////////////////
    for (genvar k = 0; k < `SW_NUM_CELLS; k++) begin : g_cell
        sw_cell #(
            .INDEX (k)
        ) cell_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .cfg      (cfg),
            .slot     (slots[k]),
            .beat_in  (beat_chain[k]),
            .link_in  (link_chain[k]),
            .beat_out (beat_chain[k+1]),
            .link_out (link_chain[k+1])
        );
    end

    assign tail_beat = beat_chain[`SW_NUM_CELLS];
    assign tail_link = link_chain[`SW_NUM_CELLS];

endmodule

//--- verilog/best_hit_tracker.sv
// best hit tracker
// follows the max leaving the array and reports the best hit at the last beat

`timescale 1ns/1ps

module best_hit_tracker import sw_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  target_beat_t  tail_beat,
    input  cell_link_t    tail_link,
    output align_result_t result,
    output logic          result_valid   // one cycle pulse
);

    tpos_t         t_count;      // base beats seen since the start beat
    align_result_t best;         // best hit so far in this target
    align_result_t next_best;
    logic          base_beat;
    logic          rise;

    assign base_beat = tail_beat.valid && !tail_beat.start;

    //////////////////////////////////////////////////
    // best hit selection
    //////////////////////////////////////////////////
    always_comb begin
        rise      = base_beat && (tail_link.h_max > best.best_score);  // strict, first hit kept
        next_best = best;
        if (rise) begin
            next_best.best_score      = tail_link.h_max;
            next_best.best_query_pos  = tail_link.h_max_i;
            next_best.best_target_pos = t_count;      // position of this beat
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t_count      <= '0;
            best         <= '0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= base_beat && tail_beat.last;
            if (tail_beat.valid && tail_beat.start) begin
                t_count <= '0;
                best    <= '0;
            end else if (base_beat) begin
                t_count <= t_count + 1'b1;
                best    <= next_best;
                if (tail_beat.last)
                    result <= next_best;              // held until the next report
            end
        end
    end

    // a start beat carries no base, so it can never close a target
    a_no_start_and_last: assert property (@(posedge clk) disable iff (!rst_n)
        tail_beat.valid |-> !(tail_beat.start && tail_beat.last));

endmodule

//--- verilog/sw_aligner_top.sv
// smith-waterman aligner top level
// query loader, systolic scoring array and best hit tracker

`timescale 1ns/1ps
`include "sw_macros.svh"

module sw_aligner_top import sw_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  score_cfg_t    cfg,            // stable during an alignment
    input  logic          query_clear,
    input  logic          query_load,
    input  base_t         query_base,
    input  target_beat_t  target_in,
    output align_result_t result,
    output logic          result_valid
);

    query_slot_t [`SW_NUM_CELLS-1:0] slots;
    target_beat_t                    tail_beat;
    cell_link_t                      tail_link;

    query_loader loader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .query_clear (query_clear),
        .query_load  (query_load),
        .query_base  (query_base),
        .slots       (slots)
    );

    sw_array array_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .slots     (slots),
        .beat_in   (target_in),
        .tail_beat (tail_beat),
        .tail_link (tail_link)
    );

    best_hit_tracker tracker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tail_beat    (tail_beat),
        .tail_link    (tail_link),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- sim/sw_ref_model.svh
// smith-waterman reference model and the stimulus table
// linear gap with zero clip, ties go to the first target position then the lowest query index

`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

localparam int NUM_ROWS = 7;

string         query_tab  [NUM_ROWS];   // bases as A/C/G/T letters
string         target_tab [NUM_ROWS];
score_cfg_t    cfg_tab    [NUM_ROWS];
align_result_t expect_tab [NUM_ROWS];

// columns are scanned in target order, rows in query order
function automatic align_result_t sw_reference(string q, string t, score_cfg_t cfg);
    int            prev_col [`SW_NUM_CELLS];   // H of the previous target base
    int            cur_col  [`SW_NUM_CELLS];
    int            diag;
    int            up;
    int            h;
    align_result_t res;
    res      = '0;
    prev_col = '{default: 0};
    cur_col  = '{default: 0};
    for (int j = 0; j < t.len(); j++) begin
        up = 0;                                          // row above the query
        for (int i = 0; i < q.len(); i++) begin
            diag = (i == 0) ? 0 : prev_col[i-1];
            h    = diag + ((q[i] == t[j]) ? int'(cfg.match) : int'(cfg.mismatch));
            if (prev_col[i] + int'(cfg.gap_open) > h)
                h = prev_col[i] + int'(cfg.gap_open);    // gap along the target
            if (up + int'(cfg.gap_open) > h)
                h = up + int'(cfg.gap_open);             // gap along the query
            if (h < 0)
                h = 0;                                   // local alignment floor
            cur_col[i] = h;
            up         = h;
            if (h > int'(res.best_score)) begin          // strict, so earlier hits win
                res.best_score      = score_t'(h);
                res.best_query_pos  = qpos_t'(i);
                res.best_target_pos = tpos_t'(j);
            end
        end
        prev_col = cur_col;
    end
    return res;
endfunction

function automatic void add_row(int r, string q, string t, int match_s, int mis_s, int gap_s);
    query_tab[r]  = q;
    target_tab[r] = t;
    cfg_tab[r]    = {score_t'(match_s), score_t'(mis_s), score_t'(gap_s)};
    expect_tab[r] = sw_reference(q, t, cfg_tab[r]);
endfunction

function automatic void build_table();
    add_row(0, "ACGTTGCA", "TTACGTTGCAGG", 2, -1, -2);   // exact match, full query
    add_row(1, "GATT",     "CCGATTACGATT", 3, -2, -2);   // short query, two equal hits
    add_row(2, "ACG",      "ACGTTACGA",    1, -1, -1);
    add_row(3, "AAGGTTCC", "TAAGGCTTCCA",  2, -3, -1);   // needs one gap
    add_row(4, "TTTT",     "GGGCCCAAA",    1, -1, -1);   // nothing aligns, score stays 0
    add_row(5, "ACGTACGT", "TGCATGCAACGT", 1,  0,  0);
    add_row(6, "C",        "GAGCTC",       4, -2, -3);   // single enabled cell
endfunction

`endif

//--- sim/sw_aligner_tb.sv
// smith-waterman aligner testbench
// every table row runs once back to back and once with random valid-low gaps

`timescale 1ns/1ps
`include "sw_macros.svh"

module sw_aligner_tb import sw_pkg::*; ();

    localparam int RESULT_TIMEOUT = 200;   // negedges

    logic          clk;
    logic          rst_n;
    score_cfg_t    cfg;
    logic          query_clear;
    logic          query_load;
    base_t         query_base;
    target_beat_t  target_in;
    align_result_t result;
    logic          result_valid;
    int            seed;

    `include "sw_ref_model.svh"

    sw_aligner_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .query_clear  (query_clear),
        .query_load   (query_load),
        .query_base   (query_base),
        .target_in    (target_in),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic stop_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, int got, int expected);
        assert (got == expected) else begin
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, expected);
            stop_run("wrong value");
        end
    endtask

    function automatic base_t base_code(byte c);
        case (c)
            "A":     return 2'd0;
            "C":     return 2'd1;
            "G":     return 2'd2;
            default: return 2'd3;   // T
        endcase
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    // optional idle cycles, then one beat, no report may show up meanwhile
    task automatic send_beat(target_beat_t beat, bit gaps);
        int idle;
        idle = gaps ? ($random(seed) & 3) : 0;
        repeat (idle) begin
            check_value("result_valid", int'(result_valid), 0);
            target_in = '0;
            @(negedge clk);
        end
        check_value("result_valid", int'(result_valid), 0);
        target_in = beat;
        @(negedge clk);
        target_in = '0;
    endtask

    // entered one negedge after the last beat went in
    task automatic wait_result(output int cycles);
        cycles = 1;
        while (!result_valid) begin
            if (cycles >= RESULT_TIMEOUT)
                stop_run("timeout: result_valid never rose after the last target beat");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic run_row(int r, bit gaps);
        string        q;
        string        t;
        int           cycles;
        target_beat_t beat;
        q           = query_tab[r];
        t           = target_tab[r];
        cfg         = cfg_tab[r];
        query_clear = 1'b1;
        @(negedge clk);
        query_clear = 1'b0;
        for (int i = 0; i < q.len(); i++) begin
            query_load = 1'b1;
            query_base = base_code(q[i]);
            @(negedge clk);
        end
        query_load = 1'b0;
        query_base = '0;
        beat = '{valid: 1'b1, start: 1'b1, last: 1'b0, base: 2'd0};
        send_beat(beat, gaps);
        for (int j = 0; j < t.len(); j++) begin
            beat = '{valid: 1'b1, start: 1'b0, last: (j == t.len() - 1), base: base_code(t[j])};
            send_beat(beat, gaps);
        end
        wait_result(cycles);
        // one edge takes the beat in, then one edge per cell to reach the tracker
        check_value("result_valid latency", cycles, `SW_NUM_CELLS + 1);
        check_value("result.best_score", int'(result.best_score),
                    int'(expect_tab[r].best_score));
        check_value("result.best_query_pos", int'(result.best_query_pos),
                    int'(expect_tab[r].best_query_pos));
        check_value("result.best_target_pos", int'(result.best_target_pos),
                    int'(expect_tab[r].best_target_pos));
        @(negedge clk);
        check_value("result_valid", int'(result_valid), 0);   // single cycle pulse
    endtask

    initial begin
        seed        = 15333;
        rst_n       = 1'b0;
        cfg         = '0;
        query_clear = 1'b0;
        query_load  = 1'b0;
        query_base  = '0;
        target_in   = '0;
        build_table();
        // exact match row, 8 bases at match 2 ending on target base 9
        check_value("model best_score, row 0", int'(expect_tab[0].best_score), 16);
        check_value("model best_query_pos, row 0", int'(expect_tab[0].best_query_pos), 7);
        check_value("model best_target_pos, row 0", int'(expect_tab[0].best_target_pos), 9);
        repeat (16) begin
            @(negedge clk);
            check_value("result_valid", int'(result_valid), 0);
        end
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int pass = 0; pass < 2; pass++)
                run_row(r, pass == 1);   // second pass with gaps
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
+incdir+sim
verilog/sw_pkg.sv
verilog/query_loader.sv
verilog/sw_cell.sv
verilog/sw_array.sv
verilog/best_hit_tracker.sv
verilog/sw_aligner_top.sv
sim/sw_aligner_tb.sv

//--- Makefile
TOP = sw_aligner_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
